// ==== tb/front_trace.txt ====
# M byte_addr word | C cycles redirect redirect_pc wb_valid wb_rd wb_data
# E group pc rd rs1_data rs2_data imm alu_op ctrl (all hex except counts and group)
M 00000000 00508193
M 00000004 00508233
M 00000008 40010333
M 0000000c 002003b3
M 00000010 fe20ac23
M 00000014 00208863
M 00000018 12345437
M 0000001c 00001497
M 00000020 fe1ff0ef
M 00000024 00410067
M 00000028 00c0a503
M 0000002c 002505b3
M 00000030 00012603
M 00000034 fff08693
M 00000038 0020c733
M 0000003c 00100893
M 00000080 005167b3
M 00000084 00a5850b
M 00000088 0f02f813
C 1 0 00000000 1 01 11111111
C 1 0 00000000 1 02 22222222
C 1 0 00000000 1 05 55555555
C 1 0 00000000 1 00 deadbeef
C 9 0 00000000 0 00 00000000
C 1 0 00000000 1 0a a0a0a0a0
C 2 0 00000000 0 00 00000000
C 1 1 00000080 0 00 00000000
C 5 0 00000000 0 00 00000000
E 0 00000000 03 11111111 00000000 00000005 0 21
E 0 00000004 04 11111111 55555555 00000000 0 01
E 0 00000008 06 22222222 00000000 00000000 1 01
E 0 0000000c 07 00000000 22222222 00000000 0 01
E 1 00000010 18 11111111 22222222 fffffff8 0 24
E 1 00000014 10 11111111 22222222 00000010 1 08
E 1 00000018 08 00000000 00000000 12345000 a 21
E 1 0000001c 09 00000000 00000000 00001000 0 61
E 1 00000020 01 00000000 11111111 ffffffe0 0 71
E 1 00000024 00 22222222 00000000 00000004 0 31
E 2 00000028 0a 11111111 00000000 0000000c 0 23
E 2 0000002c 0b a0a0a0a0 22222222 00000000 0 01
E 2 00000030 0c 22222222 00000000 00000000 0 23
E 2 00000034 0d 11111111 00000000 ffffffff 0 21
E 3 00000080 0f 22222222 55555555 00000000 3 01
E 4 00000084 0a 00000000 a0a0a0a0 00000000 0 80
E 4 00000088 10 55555555 00000000 000000f0 2 21

// ==== sim.f ====
+incdir+rtl
rtl/rv_front_pkg.sv
rtl/fetch_unit.sv
rtl/ifid_reg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/idex_reg.sv
rtl/rv_front_top.sv
tb/front_checker.sv
tb/tb_rv_front.sv

// ==== Bender.yml ====
package:
  name: rv_front

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_front_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/ifid_reg.sv
      - rtl/inst_decoder.sv
      - rtl/reg_file.sv
      - rtl/hazard_unit.sv
      - rtl/idex_reg.sv
      - rtl/rv_front_top.sv
  - target: test
    files:
      - tb/front_checker.sv
      - tb/tb_rv_front.sv

// ==== tb/tb_rv_front.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_front;

    import rv_front_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MEM_WORDS  = 64;
    localparam int MAX_STEPS  = 32;

    logic     clk;
    logic     reset;
    word_t    imem_addr;
    word_t    imem_data;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     redirect_valid;
    word_t    redirect_pc;
    logic     ex_valid;
    word_t    ex_pc;
    reg_idx_t ex_rd;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    word_t    ex_rs1_data;
    word_t    ex_rs2_data;
    word_t    ex_imm;
    alu_op_t  ex_alu_op;
    ctrl_t    ex_ctrl;
    int       checked;
    int       errors;
    int       pending;

    word_t    mem [MEM_WORDS];

    // One entry per C line, held for step_count cycles
    int       step_count [MAX_STEPS];
    logic     step_redirect [MAX_STEPS];
    word_t    step_rpc [MAX_STEPS];
    logic     step_wb [MAX_STEPS];
    reg_idx_t step_rd [MAX_STEPS];
    word_t    step_data [MAX_STEPS];
    int       n_steps = 0;
    int       total_cycles = 0;
    int       n_expected = 0;
    logic     trace_ok = 1'b0;
    logic     trace_loaded = 1'b0;

    assign imem_data = mem[imem_addr[7:2]];

    rv_front_top i_rv_front_top (
        .clk            (clk),
        .reset          (reset),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_rd          (ex_rd),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_alu_op      (ex_alu_op),
        .ex_ctrl        (ex_ctrl)
    );

    front_checker i_front_checker (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_rd         (ex_rd),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .ex_rs1_data   (ex_rs1_data),
        .ex_rs2_data   (ex_rs2_data),
        .ex_imm        (ex_imm),
        .ex_alu_op     (ex_alu_op),
        .ex_ctrl       (ex_ctrl),
        .checked_count (checked),
        .error_count   (errors),
        .pending_count (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_trace;
        int          fd;
        int          code;
        int          grp;
        int          cnt;
        string       line;
        word_t       instr_word;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] a5;
        logic [31:0] a6;
        fd = $fopen("tb/front_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                if (line.getc(0) == "M") begin
                    code = $sscanf(line, "M %h %h", a0, a1);
                    mem[a0[7:2]] = a1;
                end else if (line.getc(0) == "C" && n_steps < MAX_STEPS) begin
                    code = $sscanf(line, "C %d %h %h %h %h %h", cnt, a0, a1, a2, a3, a4);
                    step_count[n_steps]    = cnt;
                    step_redirect[n_steps] = a0[0];
                    step_rpc[n_steps]      = a1;
                    step_wb[n_steps]       = a2[0];
                    step_rd[n_steps]       = a3[4:0];
                    step_data[n_steps]     = a4;
                    total_cycles += cnt;
                    n_steps++;
                end else if (line.getc(0) == "E") begin
                    code = $sscanf(line, "E %d %h %h %h %h %h %h %h",
                                   grp, a0, a1, a2, a3, a4, a5, a6);
                    // Source register numbers sit at the RV32I field positions
                    instr_word = mem[a0[7:2]];
                    i_front_checker.add_expected(grp, a0, a1[4:0],
                                                 instr_word[19:15], instr_word[24:20],
                                                 a2, a3, a4, a5[3:0], a6[7:0]);
                    n_expected++;
                end
            end
        end
        $fclose(fd);
        trace_ok = 1'b1;
    endtask

    initial begin : stimulus
        void'($urandom(6));
        // Words outside the program get arbitrary contents
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom();
        end
        reset          = 1'b1;
        wb_valid       = 1'b0;
        wb_rd          = '0;
        wb_data        = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        load_trace();
        if (!trace_ok) begin
            $display("could not read trace file tb/front_trace.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (4) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            for (int s = 0; s < n_steps; s++) begin
                for (int c = 0; c < step_count[s]; c++) begin
                    redirect_valid = step_redirect[s];
                    redirect_pc    = step_rpc[s];
                    wb_valid       = step_wb[s];
                    wb_rd          = step_rd[s];
                    wb_data        = step_data[s];
                    @(negedge clk);
                end
            end
            redirect_valid = 1'b0;
            wb_valid       = 1'b0;
            wait (pending == 0);
            @(negedge clk);
            i_front_checker.close_groups();
            $display("operations checked %0d of %0d, errors %0d", checked, n_expected, errors);
            if (errors == 0 && checked == n_expected && checked > 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = (4 + total_cycles + 20) * CLK_PERIOD;
        #(limit);
        $display("run timed out with %0d operations missing", pending);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/front_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module front_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  rv_front_pkg::word_t    ex_pc,
    input  rv_front_pkg::reg_idx_t ex_rd,
    input  rv_front_pkg::reg_idx_t ex_rs1,
    input  rv_front_pkg::reg_idx_t ex_rs2,
    input  rv_front_pkg::word_t    ex_rs1_data,
    input  rv_front_pkg::word_t    ex_rs2_data,
    input  rv_front_pkg::word_t    ex_imm,
    input  rv_front_pkg::alu_op_t  ex_alu_op,
    input  rv_front_pkg::ctrl_t    ex_ctrl,
    output int                     checked_count,
    output int                     error_count,
    output int                     pending_count
);

    import rv_front_pkg::*;

    localparam int MAX_OPS = 64;

    int       exp_group [MAX_OPS];
    word_t    exp_pc [MAX_OPS];
    reg_idx_t exp_rd [MAX_OPS];
    reg_idx_t exp_rs1 [MAX_OPS];
    reg_idx_t exp_rs2 [MAX_OPS];
    word_t    exp_rs1_data [MAX_OPS];
    word_t    exp_rs2_data [MAX_OPS];
    word_t    exp_imm [MAX_OPS];
    alu_op_t  exp_alu_op [MAX_OPS];
    ctrl_t    exp_ctrl [MAX_OPS];

    int   n_exp = 0;
    int   beats = 0;
    int   beat_errors = 0;
    int   cur_group = -1;
    int   group_errors = 0;
    int   group_beats = 0;
    logic overflow = 1'b0;

    assign checked_count = beats;
    assign error_count   = beat_errors + (overflow ? 1 : 0);
    assign pending_count = n_exp - beats;

    task automatic add_expected(input int grp, input word_t pc, input reg_idx_t rd,
                                input reg_idx_t rs1, input reg_idx_t rs2,
                                input word_t rs1_data, input word_t rs2_data,
                                input word_t imm, input alu_op_t alu_op, input ctrl_t ctrl);
        if (n_exp < MAX_OPS) begin
            exp_group[n_exp]    = grp;
            exp_pc[n_exp]       = pc;
            exp_rd[n_exp]       = rd;
            exp_rs1[n_exp]      = rs1;
            exp_rs2[n_exp]      = rs2;
            exp_rs1_data[n_exp] = rs1_data;
            exp_rs2_data[n_exp] = rs2_data;
            exp_imm[n_exp]      = imm;
            exp_alu_op[n_exp]   = alu_op;
            exp_ctrl[n_exp]     = ctrl;
            n_exp++;
        end else begin
            $display("trace holds more expected operations than the checker can store");
            overflow = 1'b1;
        end
    endtask

    task automatic compare_field(input string name, input word_t pc, input logic [31:0] got,
                                 input logic [31:0] exp, inout int errs);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: pc %08h field %s got %08h expected %08h",
                     $time, pc, name, got, exp);
            errs++;
        end
    endtask

    task automatic report_group;
        if (cur_group >= 0) begin
            if (group_errors == 0) begin
                $display("test group %0d: pass, %0d operations", cur_group, group_beats);
            end else begin
                $display("test group %0d: fail, %0d errors in %0d operations",
                         cur_group, group_errors, group_beats);
            end
        end
    endtask

    task automatic close_groups;
        report_group();
    endtask

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin : sample
        int errs;
        int i;
        if (!reset && ex_valid && (beats < n_exp)) begin
            i = beats;
            if (exp_group[i] != cur_group) begin
                report_group();
                cur_group    = exp_group[i];
                group_errors = 0;
                group_beats  = 0;
            end
            errs = 0;
            compare_field("pc", exp_pc[i], ex_pc, exp_pc[i], errs);
            compare_field("rd", exp_pc[i], 32'(ex_rd), 32'(exp_rd[i]), errs);
            compare_field("rs1", exp_pc[i], 32'(ex_rs1), 32'(exp_rs1[i]), errs);
            compare_field("rs2", exp_pc[i], 32'(ex_rs2), 32'(exp_rs2[i]), errs);
            compare_field("rs1_data", exp_pc[i], ex_rs1_data, exp_rs1_data[i], errs);
            compare_field("rs2_data", exp_pc[i], ex_rs2_data, exp_rs2_data[i], errs);
            compare_field("imm", exp_pc[i], ex_imm, exp_imm[i], errs);
            compare_field("alu_op", exp_pc[i], 32'(ex_alu_op), 32'(exp_alu_op[i]), errs);
            compare_field("ctrl", exp_pc[i], 32'(ex_ctrl), 32'(exp_ctrl[i]), errs);
            group_errors += errs;
            beat_errors  += errs;
            group_beats++;
            beats++;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_front_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_front_top (
    input  logic                   clk,
    input  logic                   reset,
    output rv_front_pkg::word_t    imem_addr,
    input  rv_front_pkg::word_t    imem_data,
    input  logic                   wb_valid,
    input  rv_front_pkg::reg_idx_t wb_rd,
    input  rv_front_pkg::word_t    wb_data,
    input  logic                   redirect_valid,
    input  rv_front_pkg::word_t    redirect_pc,
    output logic                   ex_valid,
    output rv_front_pkg::word_t    ex_pc,
    output rv_front_pkg::reg_idx_t ex_rd,
    output rv_front_pkg::reg_idx_t ex_rs1,
    output rv_front_pkg::reg_idx_t ex_rs2,
    output rv_front_pkg::word_t    ex_rs1_data,
    output rv_front_pkg::word_t    ex_rs2_data,
    output rv_front_pkg::word_t    ex_imm,
    output rv_front_pkg::alu_op_t  ex_alu_op,
    output rv_front_pkg::ctrl_t    ex_ctrl
);

    import rv_front_pkg::*;

    word_t    pc;
    word_t    id_pc;
    word_t    id_instr;
    logic     id_valid;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     uses_rs1;
    logic     uses_rs2;
    word_t    imm;
    alu_op_t  alu_op;
    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     stall;
    logic     ifid_write;

    assign imem_addr = pc;

    // A redirect must still reach IF/ID to flush it
    assign ifid_write = !stall || redirect_valid;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    ifid_reg i_ifid_reg (
        .clk         (clk),
        .reset       (reset),
        .write       (ifid_write),
        .flush       (redirect_valid),
        .instruction (imem_data),
        .pc_in       (pc),
        .id_pc       (id_pc),
        .id_instr    (id_instr),
        .id_valid    (id_valid)
    );

    inst_decoder i_inst_decoder (
        .instr    (id_instr),
        .valid    (id_valid),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2),
        .imm      (imm),
        .alu_op   (alu_op),
        .ctrl     (ctrl)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    hazard_unit i_hazard_unit (
        .id_valid    (id_valid),
        .id_rs1      (rs1),
        .id_rs2      (rs2),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .ex_valid    (ex_valid),
        .ex_mem_read (ex_ctrl[CTRL_MEM_READ]),
        .ex_rd       (ex_rd),
        .stall       (stall)
    );

    idex_reg i_idex_reg (
        .clk         (clk),
        .reset       (reset),
        .bubble      (stall),
        .flush       (redirect_valid),
        .id_valid    (id_valid),
        .id_pc       (id_pc),
        .id_rs1      (rs1),
        .id_rs2      (rs2),
        .id_rd       (rd),
        .id_rs1_data (rs1_data),
        .id_rs2_data (rs2_data),
        .id_imm      (imm),
        .id_alu_op   (alu_op),
        .id_ctrl     (ctrl),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rd       (ex_rd),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_imm      (ex_imm),
        .ex_alu_op   (ex_alu_op),
        .ex_ctrl     (ex_ctrl)
    );

endmodule

`default_nettype wire

// ==== rtl/idex_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module idex_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bubble,
    input  logic                   flush,
    input  logic                   id_valid,
    input  rv_front_pkg::word_t    id_pc,
    input  rv_front_pkg::reg_idx_t id_rs1,
    input  rv_front_pkg::reg_idx_t id_rs2,
    input  rv_front_pkg::reg_idx_t id_rd,
    input  rv_front_pkg::word_t    id_rs1_data,
    input  rv_front_pkg::word_t    id_rs2_data,
    input  rv_front_pkg::word_t    id_imm,
    input  rv_front_pkg::alu_op_t  id_alu_op,
    input  rv_front_pkg::ctrl_t    id_ctrl,
    output logic                   ex_valid,
    output rv_front_pkg::word_t    ex_pc,
    output rv_front_pkg::reg_idx_t ex_rs1,
    output rv_front_pkg::reg_idx_t ex_rs2,
    output rv_front_pkg::reg_idx_t ex_rd,
    output rv_front_pkg::word_t    ex_rs1_data,
    output rv_front_pkg::word_t    ex_rs2_data,
    output rv_front_pkg::word_t    ex_imm,
    output rv_front_pkg::alu_op_t  ex_alu_op,
    output rv_front_pkg::ctrl_t    ex_ctrl
);

    logic kill;

    assign kill = bubble || flush;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end else if (kill) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end else begin
            ex_valid <= id_valid;
            ex_ctrl  <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc       <= id_pc;
        ex_rs1      <= id_rs1;
        ex_rs2      <= id_rs2;
        ex_rd       <= id_rd;
        ex_rs1_data <= id_rs1_data;
        ex_rs2_data <= id_rs2_data;
        ex_imm      <= id_imm;
        ex_alu_op   <= id_alu_op;
    end

    // Decoder zeroes control for an invalid IF/ID slot
    a_bubble_no_ctrl: assert property (
        @(posedge clk) disable iff (reset)
        !ex_valid |-> (ex_ctrl == '0)
    ) else $error("ID/EX bubble carries control 0x%02h", ex_ctrl);

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  logic                   id_valid,
    input  rv_front_pkg::reg_idx_t id_rs1,
    input  rv_front_pkg::reg_idx_t id_rs2,
    input  logic                   uses_rs1,
    input  logic                   uses_rs2,
    input  logic                   ex_valid,
    input  logic                   ex_mem_read,
    input  rv_front_pkg::reg_idx_t ex_rd,
    output logic                   stall
);

    logic load_in_ex;
    logic rs1_match;
    logic rs2_match;

    // Load result not ready until after execute, x0 never counts
    assign load_in_ex = ex_valid && ex_mem_read && (ex_rd != '0);

    assign rs1_match = uses_rs1 && (id_rs1 == ex_rd);
    assign rs2_match = uses_rs2 && (id_rs2 == ex_rd);

    // Clears itself once the bubble reaches ID/EX
    assign stall = id_valid && load_in_ex && (rs1_match || rs2_match);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_front_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_front_pkg::reg_idx_t rs1,
    input  rv_front_pkg::reg_idx_t rs2,
    output rv_front_pkg::word_t    rs1_data,
    output rv_front_pkg::word_t    rs2_data,
    input  logic                   wb_valid,
    input  rv_front_pkg::reg_idx_t wb_rd,
    input  rv_front_pkg::word_t    wb_data
);

    import rv_front_pkg::*;

    // x0 has no storage
    word_t regs [1:`RV_NUM_REGS-1];

    // Same-cycle writeback is forwarded to the reader
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            read_port = '0;
        end else if (wb_valid && (wb_rd == idx)) begin
            read_port = wb_data;
        end else begin
            read_port = regs[idx];
        end
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_front_defines.svh"

module inst_decoder (
    input  rv_front_pkg::word_t    instr,
    input  logic                   valid,
    output rv_front_pkg::reg_idx_t rs1,
    output rv_front_pkg::reg_idx_t rs2,
    output rv_front_pkg::reg_idx_t rd,
    output logic                   uses_rs1,
    output logic                   uses_rs2,
    output rv_front_pkg::word_t    imm,
    output rv_front_pkg::alu_op_t  alu_op,
    output rv_front_pkg::ctrl_t    ctrl
);

    import rv_front_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // Shared by OP and OP-IMM; alt is instr[30]
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        case (f3)
            3'b000:  arith_op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl     = '0;
        alu_op   = ALU_ADD;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            `RV_OP_LOAD: begin
                imm = imm_i;
                uses_rs1 = 1'b1;
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_MEM_READ] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            `RV_OP_STORE: begin
                imm = imm_s;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                ctrl[CTRL_MEM_WRITE] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            `RV_OP_BRANCH: begin
                imm = imm_b;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                ctrl[CTRL_BRANCH] = 1'b1;
                // Comparison kind from funct3[2:1]
                case (funct3[2:1])
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: alu_op = ALU_SUB;
                endcase
            end
            `RV_OP_JAL: begin
                imm = imm_j;
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_JUMP] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
                ctrl[CTRL_PC_SRC_A] = 1'b1;
            end
            `RV_OP_JALR: begin
                imm = imm_i;
                uses_rs1 = 1'b1;
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_JUMP] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            `RV_OP_IMM: begin
                imm = imm_i;
                uses_rs1 = 1'b1;
                alu_op = arith_op(funct3, instr[30], 1'b0);
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            `RV_OP_REG: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                alu_op = arith_op(funct3, instr[30], 1'b1);
                ctrl[CTRL_REG_WRITE] = 1'b1;
            end
            `RV_OP_LUI: begin
                imm = imm_u;
                alu_op = ALU_PASS_B;
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            `RV_OP_AUIPC: begin
                imm = imm_u;
                ctrl[CTRL_REG_WRITE] = 1'b1;
                ctrl[CTRL_ALU_SRC_IMM] = 1'b1;
                ctrl[CTRL_PC_SRC_A] = 1'b1;
            end
            default: begin
                ctrl[CTRL_ILLEGAL] = 1'b1;
            end
        endcase

        // Bubbles carry no control and request no operands
        if (!valid) begin
            ctrl     = '0;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ifid_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifid_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                write,
    input  logic                flush,
    input  rv_front_pkg::word_t instruction,
    input  rv_front_pkg::word_t pc_in,
    output rv_front_pkg::word_t id_pc,
    output rv_front_pkg::word_t id_instr,
    output logic                id_valid
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_pc    <= '0;
            id_instr <= '0;
            id_valid <= 1'b0;
        end else if (write) begin
            id_pc <= pc_in;
            if (flush) begin
                // Zero word decodes as a bubble once valid is low
                id_instr <= '0;
                id_valid <= 1'b0;
            end else begin
                id_instr <= instruction;
                id_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_front_defines.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                redirect_valid,
    input  rv_front_pkg::word_t redirect_pc,
    output rv_front_pkg::word_t pc
);

    // Redirect beats stall, stall beats the sequential step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // Redirect targets come from execute and must keep alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("fetch pc 0x%08h not word aligned", pc);

endmodule

`default_nettype wire

// ==== rtl/rv_front_pkg.sv ====
`default_nettype none

`include "rv_front_defines.svh"

package rv_front_pkg;

    typedef logic [`RV_XLEN-1:0]              word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [3:0]                       alu_op_t;
    typedef logic [7:0]                       ctrl_t;

    // ALU operations requested from execute
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Bit positions inside ctrl_t
    localparam int CTRL_REG_WRITE   = 0;
    localparam int CTRL_MEM_READ    = 1;
    localparam int CTRL_MEM_WRITE   = 2;
    localparam int CTRL_BRANCH      = 3;
    localparam int CTRL_JUMP        = 4;
    // Operand B from the immediate
    localparam int CTRL_ALU_SRC_IMM = 5;
    // Operand A from the pc instead of rs1
    localparam int CTRL_PC_SRC_A    = 6;
    localparam int CTRL_ILLEGAL     = 7;

endpackage

`default_nettype wire

// ==== rtl/rv_front_defines.svh ====
`ifndef RV_FRONT_DEFINES_SVH
`define RV_FRONT_DEFINES_SVH

// Datapath width and register file size
`define RV_XLEN      32
`define RV_NUM_REGS  32

// First fetch address after reset
`define RV_RESET_PC  32'h0000_0000

// RV32I major opcodes
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

`endif
